/* Bender.yml */
package:
  name: periph_top

sources:
  - include_dirs:
      - design
    files:
      - design/periph_pkg.sv
      - design/apb_io_ctrl.sv
      - design/spi_engine.sv
      - design/wii_pad_regs.sv
      - design/periph_top.sv
  - target: simulation
    include_dirs:
      - design
      - sim
    files:
      - sim/periph_tb.sv

/* design/apb_io_ctrl.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module apb_io_ctrl (
  input  logic                       clk50,
  input  logic                       SCKclock,
  input  periph_pkg::apb_req_t       apb_req_i,
  output periph_pkg::apb_rsp_t       apb_rsp_o,
  output logic                       spi_start_o,
  output periph_pkg::word_t          spi_tx_o,
  input  periph_pkg::word_t          spi_rx_i,
  input  logic                       spi_idle_i,
  output periph_pkg::pad_wr_t        pad_wr_o,
  input  periph_pkg::pad_raw_t [1:0] pad_raw_i,
  input  periph_pkg::pad_dec_t [1:0] pad_dec_i,
  output logic                       panel_pd_o
);

  periph_pkg::io_addr_t  addr;
  periph_pkg::pad_idx_t  pad_sel;
  periph_pkg::pad_word_t pad_word;
  periph_pkg::word_t     sysctl;
  periph_pkg::word_t     ticks;
  periph_pkg::word_t     rd_word;
  logic raw_hit, dec_hit;
  logic sysctl_hit, ticks_hit, spi_data_hit, spi_stat_hit;
  logic mapped, read_only;
  logic spi_wait, done, wr_done;

  function automatic periph_pkg::word_t pick_word(input periph_pkg::pad_raw_t rep,
                                                  input periph_pkg::pad_word_t idx);
    case (idx)
      2'd1:    return rep[31:16];
      2'd2:    return rep[47:32];
      default: return rep[15:0];
    endcase
  endfunction

  //////////////////////////////////////////////////
  // address decode

  assign addr = apb_req_i.addr;

  always_comb begin
    raw_hit  = 1'b0;
    dec_hit  = 1'b0;
    pad_sel  = '0;
    pad_word = '0;
    case (addr)
      `REG_PAD1_W0: {raw_hit, pad_sel, pad_word} = 4'b1_0_00;
      `REG_PAD1_W1: {raw_hit, pad_sel, pad_word} = 4'b1_0_01;
      `REG_PAD1_W2: {raw_hit, pad_sel, pad_word} = 4'b1_0_10;
      `REG_PAD2_W0: {raw_hit, pad_sel, pad_word} = 4'b1_1_00;
      `REG_PAD2_W1: {raw_hit, pad_sel, pad_word} = 4'b1_1_01;
      `REG_PAD2_W2: {raw_hit, pad_sel, pad_word} = 4'b1_1_10;
      `REG_PAD1_D0: {dec_hit, pad_sel, pad_word} = 4'b1_0_00;
      `REG_PAD1_D1: {dec_hit, pad_sel, pad_word} = 4'b1_0_01;
      `REG_PAD1_D2: {dec_hit, pad_sel, pad_word} = 4'b1_0_10;
      `REG_PAD2_D0: {dec_hit, pad_sel, pad_word} = 4'b1_1_00;
      `REG_PAD2_D1: {dec_hit, pad_sel, pad_word} = 4'b1_1_01;
      `REG_PAD2_D2: {dec_hit, pad_sel, pad_word} = 4'b1_1_10;
      default: ;
    endcase
  end

  assign sysctl_hit   = (addr == `REG_SYSCTL);
  assign ticks_hit    = (addr == `REG_TICKS);
  assign spi_data_hit = (addr == `REG_SPI_DATA);
  assign spi_stat_hit = (addr == `REG_SPI_STAT);

  assign mapped    = raw_hit | dec_hit | sysctl_hit | ticks_hit | spi_data_hit | spi_stat_hit;
  assign read_only = dec_hit | ticks_hit | spi_stat_hit;

  //////////////////////////////////////////////////
  // handshake

  // only a spi write into a busy engine stalls
  assign spi_wait = apb_req_i.sel & apb_req_i.write & spi_data_hit & ~spi_idle_i;
  assign done     = apb_req_i.sel & apb_req_i.enable & ~spi_wait;
  assign wr_done  = done & apb_req_i.write & mapped & ~read_only;

  always_comb begin
    rd_word = '0;  // unmapped reads 0
    if (raw_hit)
      rd_word = pick_word(pad_raw_i[pad_sel], pad_word);
    else if (dec_hit)
      rd_word = pick_word(pad_dec_i[pad_sel], pad_word);
    else if (sysctl_hit)
      rd_word = sysctl;
    else if (ticks_hit)
      rd_word = ticks;
    else if (spi_data_hit)
      rd_word = spi_rx_i;
    else if (spi_stat_hit)
      rd_word = {{(`PERIPH_DATA_W-1){1'b0}}, spi_idle_i};
  end

  assign apb_rsp_o.rdata  = apb_req_i.write ? '0 : rd_word;
  assign apb_rsp_o.ready  = ~spi_wait;
  assign apb_rsp_o.slverr = ~mapped | (apb_req_i.write & read_only);

  assign spi_start_o   = wr_done & spi_data_hit;
  assign spi_tx_o      = apb_req_i.wdata;
  assign pad_wr_o.en   = wr_done & raw_hit;
  assign pad_wr_o.pad  = pad_sel;
  assign pad_wr_o.word = pad_word;
  assign pad_wr_o.data = apb_req_i.wdata;

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      sysctl <= '0;
      ticks  <= '0;
    end else begin
      ticks <= ticks + periph_pkg::word_t'(1);
      if (wr_done && sysctl_hit)
        sysctl <= apb_req_i.wdata;
    end
  end

  assign panel_pd_o = sysctl[0];  // panel power-down

  a_start_when_idle : assert property (@(posedge clk50) disable iff (SCKclock)
    spi_start_o |-> spi_idle_i ##1 !spi_idle_i)
    else $error("spi start not taken by an idle engine");

  a_err_reads_zero : assert property (@(posedge clk50) disable iff (SCKclock)
    (apb_req_i.sel && apb_req_i.enable && apb_rsp_o.slverr) |-> (apb_rsp_o.rdata == '0))
    else $error("nonzero rdata with slverr");

endmodule

/* design/periph_consts.svh */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

`define PERIPH_DATA_W   16
`define PERIPH_ADDR_W   12

//////////////////////////////////////////////////
// register map

`define REG_PAD1_W0     12'h004  // raw report, low word first
`define REG_PAD1_W1     12'h005
`define REG_PAD1_W2     12'h006
`define REG_PAD2_W0     12'h007
`define REG_PAD2_W1     12'h008
`define REG_PAD2_W2     12'h009
`define REG_PAD1_D0     12'h00a  // decoded fields, read only
`define REG_PAD1_D1     12'h00b
`define REG_PAD1_D2     12'h00c
`define REG_PAD2_D0     12'h00d
`define REG_PAD2_D1     12'h00e
`define REG_PAD2_D2     12'h00f
`define REG_SYSCTL      12'h014
`define REG_TICKS       12'h015
`define REG_SPI_DATA    12'h020
`define REG_SPI_STAT    12'h021

//////////////////////////////////////////////////
`define SPI_BITS        16
`define SPI_HALF_CYCLES 32       // two per bit
`define PAD_RESET_VAL   48'h1234_5678_9abc

`endif

/* design/periph_pkg.sv */
`include "periph_consts.svh"

package periph_pkg;

  typedef logic [`PERIPH_DATA_W-1:0]   word_t;
  typedef logic [`PERIPH_ADDR_W-1:0]   io_addr_t;
  typedef logic [3*`PERIPH_DATA_W-1:0] pad_raw_t;  // three bus words
  typedef logic [47:0]                 pad_dec_t;  // six byte fields
  typedef logic                        pad_idx_t;
  typedef logic [1:0]                  pad_word_t;

  // apb request, driven by the requester
  typedef struct packed {
    logic     sel;
    logic     enable;
    logic     write;
    io_addr_t addr;
    word_t    wdata;
  } apb_req_t;

  typedef struct packed {
    word_t rdata;
    logic  ready;
    logic  slverr;
  } apb_rsp_t;

  // one raw word into one pad report
  typedef struct packed {
    logic      en;
    pad_idx_t  pad;
    pad_word_t word;
    word_t     data;
  } pad_wr_t;

  typedef enum logic {SPI_IDLE, SPI_SHIFT} spi_state_e;

endpackage

/* design/periph_top.sv */
`timescale 1ns/1ps

module periph_top (
  input  logic                 clk50,
  input  logic                 SCKclock,
  input  periph_pkg::apb_req_t apb_req_i,
  output periph_pkg::apb_rsp_t apb_rsp_o,
  input  logic                 spi_miso_i,
  output logic                 spi_sck_o,
  output logic                 spi_mosi_o,
  output logic                 panel_pd_o
);

  logic                       spi_start;
  periph_pkg::word_t          spi_tx;
  periph_pkg::word_t          spi_rx;
  logic                       spi_idle;
  periph_pkg::pad_wr_t        pad_wr;
  periph_pkg::pad_raw_t [1:0] pad_raw;
  periph_pkg::pad_dec_t [1:0] pad_dec;

  apb_io_ctrl u_ctrl (
    .clk50       (clk50),
    .SCKclock    (SCKclock),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .spi_start_o (spi_start),
    .spi_tx_o    (spi_tx),
    .spi_rx_i    (spi_rx),
    .spi_idle_i  (spi_idle),
    .pad_wr_o    (pad_wr),
    .pad_raw_i   (pad_raw),
    .pad_dec_i   (pad_dec),
    .panel_pd_o  (panel_pd_o)
  );

  spi_engine u_spi (
    .clk50    (clk50),
    .SCKclock (SCKclock),
    .start_i  (spi_start),
    .tx_i     (spi_tx),
    .rx_o     (spi_rx),
    .idle_o   (spi_idle),
    .sck_o    (spi_sck_o),
    .mosi_o   (spi_mosi_o),
    .miso_i   (spi_miso_i)
  );

  wii_pad_regs u_pads (
    .clk50     (clk50),
    .SCKclock  (SCKclock),
    .pad_wr_i  (pad_wr),
    .pad_raw_o (pad_raw),
    .pad_dec_o (pad_dec)
  );

endmodule

/* design/spi_engine.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module spi_engine (
  input  logic              clk50,
  input  logic              SCKclock,
  input  logic              start_i,
  input  periph_pkg::word_t tx_i,
  output periph_pkg::word_t rx_o,
  output logic              idle_o,
  output logic              sck_o,
  output logic              mosi_o,
  input  logic              miso_i
);

  localparam int CNT_W = $clog2(`SPI_HALF_CYCLES);

  periph_pkg::spi_state_e state;
  logic [CNT_W-1:0]       half_cnt;
  periph_pkg::word_t      shifter;
  logic                   last_half;

  assign last_half = (half_cnt == CNT_W'(`SPI_HALF_CYCLES - 1));

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      state    <= periph_pkg::SPI_IDLE;
      half_cnt <= '0;
    end else begin
      case (state)
        periph_pkg::SPI_IDLE: begin
          if (start_i)
            state <= periph_pkg::SPI_SHIFT;
        end
        periph_pkg::SPI_SHIFT: begin
          half_cnt <= half_cnt + CNT_W'(1);  // wraps back to 0
          if (last_half)
            state <= periph_pkg::SPI_IDLE;
        end
        default: state <= periph_pkg::SPI_IDLE;
      endcase
    end
  end

  // load on start, sample miso at the end of each high half
  always_ff @(posedge clk50) begin
    if (state == periph_pkg::SPI_IDLE && start_i)
      shifter <= tx_i;
    else if (state == periph_pkg::SPI_SHIFT && half_cnt[0])
      shifter <= {shifter[`SPI_BITS-2:0], miso_i};
  end

  assign rx_o   = shifter;
  assign mosi_o = shifter[`SPI_BITS-1];
  assign sck_o  = half_cnt[0];  // low while idle
  assign idle_o = (state == periph_pkg::SPI_IDLE);

  a_sck_quiet : assert property (@(posedge clk50) disable iff (SCKclock)
    idle_o |-> !sck_o)
    else $error("sck high while idle");

endmodule

/* design/wii_pad_regs.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module wii_pad_regs (
  input  logic                       clk50,
  input  logic                       SCKclock,
  input  periph_pkg::pad_wr_t        pad_wr_i,
  output periph_pkg::pad_raw_t [1:0] pad_raw_o,
  output periph_pkg::pad_dec_t [1:0] pad_dec_o
);

  for (genvar p = 0; p < 2; p++) begin : g_pad
    periph_pkg::pad_raw_t raw;
    logic [5:0]           lx, ly;
    logic [4:0]           rx, ry, lt, rt;
    logic                 hit;

    assign hit = pad_wr_i.en && (pad_wr_i.pad == periph_pkg::pad_idx_t'(p));

    always_ff @(posedge clk50 or posedge SCKclock) begin
      if (SCKclock) begin
        raw <= `PAD_RESET_VAL;
      end else if (hit) begin
        case (pad_wr_i.word)
          2'd0:    raw[15:0]  <= pad_wr_i.data;
          2'd1:    raw[31:16] <= pad_wr_i.data;
          2'd2:    raw[47:32] <= pad_wr_i.data;
          default: ;
        endcase
      end
    end

    //////////////////////////////////////////////////
    // field decode, low 32 bits only

    assign lx = raw[5:0];
    assign ly = raw[13:8];
    assign rx = {raw[7:6], raw[15:14], raw[23]};  // split over three bytes
    assign ry = raw[20:16];
    assign lt = {raw[22:21], raw[31:29]};
    assign rt = raw[28:24];

    assign pad_raw_o[p] = raw;
    // word 2 rt/lt, word 1 ry/rx, word 0 ly/lx
    assign pad_dec_o[p] = {3'b000, rt, 3'b000, lt,
                           3'b000, ry, 3'b000, rx,
                           2'b00,  ly, 2'b00,  lx};
  end

endmodule

/* periph_top.f */
+incdir+design
+incdir+sim
design/periph_pkg.sv
design/apb_io_ctrl.sv
design/spi_engine.sv
design/wii_pad_regs.sv
design/periph_top.sv
sim/periph_tb.sv

/* sim/periph_tb_checks.svh */
//////////////////////////////////////////////////
// bus tasks

task automatic apb_transfer(input logic wr, input periph_pkg::io_addr_t addr,
                            input periph_pkg::word_t wdata, output periph_pkg::word_t rdata,
                            output logic err, output int waits);
  logic got;
  got   = 1'b0;
  waits = 0;
  rdata = '0;
  err   = 1'b0;
  req   = '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: wdata};
  @(posedge clk50);
  #2 req.enable = 1'b1;
  while (!got && waits < XFER_LIMIT) begin
    @(negedge clk50);  // mid-cycle, response settled
    if (rsp.ready) begin
      got   = 1'b1;
      rdata = rsp.rdata;
      err   = rsp.slverr;
    end else begin
      waits++;
    end
    @(posedge clk50);
  end
  #2 req = '0;
  if (!got) begin
    errors++;
    $display("%s: no ready from address %h within %0d cycles", test_name, addr, XFER_LIMIT);
  end
endtask

task automatic expect_word(input string what, input periph_pkg::word_t exp,
                           input periph_pkg::word_t act);
  assert (act === exp)
    else begin
      errors++;
      $display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, what, exp, act);
    end
endtask

// legal transfers take two cycles and no error
task automatic write_reg(input periph_pkg::io_addr_t addr, input periph_pkg::word_t data);
  periph_pkg::word_t rdata;
  logic err;
  int waits;
  apb_transfer(1'b1, addr, data, rdata, err, waits);
  expect_word("write slverr", '0, periph_pkg::word_t'(err));
  expect_word("write wait cycles", '0, periph_pkg::word_t'(waits));
endtask

task automatic read_reg(input periph_pkg::io_addr_t addr, output periph_pkg::word_t data);
  logic err;
  int waits;
  apb_transfer(1'b0, addr, '0, data, err, waits);
  expect_word("read slverr", '0, periph_pkg::word_t'(err));
  expect_word("read wait cycles", '0, periph_pkg::word_t'(waits));
endtask

//////////////////////////////////////////////////
// bus level assertions

a_stall_on_spi_write : assert property (@(posedge clk50) disable iff (SCKclock)
  (req.sel && req.enable && !rsp.ready) |-> (req.write && req.addr == `REG_SPI_DATA))
  else begin
    errors++;
    $display("%s: ready held low outside a busy SPI data write", test_name);
  end

a_pd_follows_sysctl : assert property (@(posedge clk50) disable iff (SCKclock)
  (req.sel && req.enable && rsp.ready && req.write && req.addr == `REG_SYSCTL)
  |=> (panel_pd == $past(req.wdata[0])))
  else begin
    errors++;
    $display("CHECK FAILED %s (panel_pd_o): expected %b, actual %b", test_name,
             $past(req.wdata[0]), $sampled(panel_pd));
  end

/* sim/periph_tb.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_tb;

  localparam int XFER_LIMIT = 64;
  localparam int POLL_LIMIT = 40;

  logic                 clk50;
  logic                 SCKclock;
  periph_pkg::apb_req_t req;
  periph_pkg::apb_rsp_t rsp;
  logic                 spi_sck, spi_mosi, panel_pd, err;
  int                   errors, err_mark, tests_run, tests_failed, sck_edges, waits, seed;
  string                test_name;
  periph_pkg::pad_raw_t pad_img [2];
  periph_pkg::word_t    wd, rd, w1, w2;
  periph_pkg::word_t    reset_words [3] = '{16'h9abc, 16'h5678, 16'h1234};

  periph_top UUT (
    .clk50      (clk50),
    .SCKclock   (SCKclock),
    .apb_req_i  (req),
    .apb_rsp_o  (rsp),
    .spi_miso_i (spi_mosi),  // loopback
    .spi_sck_o  (spi_sck),
    .spi_mosi_o (spi_mosi),
    .panel_pd_o (panel_pd)
  );

  always #50 clk50 = ~clk50;
  always @(posedge spi_sck) sck_edges++;

  `include "periph_tb_checks.svh"

  // byte fields of one decoded word, zero extended
  function automatic periph_pkg::word_t decode_fields(input periph_pkg::pad_raw_t r,
                                                      input int idx);
    case (idx)
      1:       return {3'b000, r[20:16], 3'b000, r[7:6], r[15:14], r[23]};
      2:       return {3'b000, r[28:24], 3'b000, r[22:21], r[31:29]};
      default: return {2'b00, r[13:8], 2'b00, r[5:0]};
    endcase
  endfunction

  task automatic wait_spi_idle();
    periph_pkg::word_t stat;
    int polls;
    stat  = '0;
    polls = 0;
    while (!stat[0] && polls < POLL_LIMIT) begin
      read_reg(`REG_SPI_STAT, stat);
      polls++;
    end
    if (!stat[0]) begin
      errors++;
      $display("%s: SPI engine still busy after %0d status polls", test_name, POLL_LIMIT);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic report_test();
    tests_run++;
    if (errors != err_mark)
      tests_failed++;
    $display("test %-12s %s", test_name, (errors == err_mark) ? "ok" : "FAILED");
  endtask

  initial begin
    #2ms;
    $display("simulation time limit reached");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    clk50    = 1'b0;
    SCKclock = 1'b1;
    req      = '0;
    seed     = 91911;
    errors   = 0;
    repeat (4) @(posedge clk50);
    #2 SCKclock = 1'b0;

    //////////////////////////////////////////////////
    start_test("reset_state");
    read_reg(`REG_SYSCTL, rd);
    expect_word("sysctl", '0, rd);
    expect_word("panel_pd_o", '0, periph_pkg::word_t'(panel_pd));
    read_reg(`REG_SPI_STAT, rd);
    expect_word("spi idle bit", 16'h0001, periph_pkg::word_t'(rd[0]));
    for (int i = 0; i < 6; i++) begin
      read_reg(`REG_PAD1_W0 + periph_pkg::io_addr_t'(i), rd);
      expect_word("pad raw", reset_words[i % 3], rd);
    end
    report_test();

    start_test("sysctl");
    for (int i = 0; i < 4; i++) begin
      wd    = periph_pkg::word_t'($random(seed));
      wd[0] = i[0];  // both pin levels
      write_reg(`REG_SYSCTL, wd);
      read_reg(`REG_SYSCTL, rd);
      expect_word("sysctl readback", wd, rd);
      expect_word("panel_pd_o", periph_pkg::word_t'(wd[0]), periph_pkg::word_t'(panel_pd));
    end
    report_test();

    start_test("pad_decode");
    for (int i = 0; i < 6; i++) begin
      wd = periph_pkg::word_t'($random(seed));
      pad_img[i / 3][16 * (i % 3) +: 16] = wd;
      write_reg(`REG_PAD1_W0 + periph_pkg::io_addr_t'(i), wd);
    end
    for (int i = 0; i < 6; i++) begin
      read_reg(`REG_PAD1_W0 + periph_pkg::io_addr_t'(i), rd);
      expect_word("pad raw", pad_img[i / 3][16 * (i % 3) +: 16], rd);
      read_reg(`REG_PAD1_D0 + periph_pkg::io_addr_t'(i), rd);
      expect_word("pad decoded", decode_fields(pad_img[i / 3], i % 3), rd);
    end
    report_test();

    //////////////////////////////////////////////////
    start_test("spi");
    sck_edges = 0;
    wd = periph_pkg::word_t'($random(seed));
    write_reg(`REG_SPI_DATA, wd);
    wait_spi_idle();
    read_reg(`REG_SPI_DATA, rd);
    expect_word("loopback word", wd, rd);
    expect_word("sck rising edges", `SPI_BITS, periph_pkg::word_t'(sck_edges));
    w1 = periph_pkg::word_t'($random(seed));
    w2 = periph_pkg::word_t'($random(seed));
    apb_transfer(1'b1, `REG_SPI_DATA, w1, rd, err, waits);
    expect_word("first write waits", '0, periph_pkg::word_t'(waits));
    apb_transfer(1'b1, `REG_SPI_DATA, w2, rd, err, waits);  // engine still busy
    assert (waits > 0 && waits <= `SPI_HALF_CYCLES)
      else begin
        errors++;
        $display("CHECK FAILED %s (stall cycles): expected 1..%0d, actual %0d",
                 test_name, `SPI_HALF_CYCLES, waits);
      end
    expect_word("second write slverr", '0, periph_pkg::word_t'(err));
    wait_spi_idle();
    read_reg(`REG_SPI_DATA, rd);
    expect_word("second loopback word", w2, rd);
    report_test();

    start_test("slverr");
    apb_transfer(1'b0, 12'h3ff, '0, rd, err, waits);
    expect_word("unmapped slverr", 16'h0001, periph_pkg::word_t'(err));
    expect_word("unmapped rdata", '0, rd);
    apb_transfer(1'b1, `REG_TICKS, 16'hffff, rd, err, waits);
    expect_word("ticks write slverr", 16'h0001, periph_pkg::word_t'(err));
    apb_transfer(1'b1, `REG_SPI_STAT, 16'hffff, rd, err, waits);
    expect_word("status write slverr", 16'h0001, periph_pkg::word_t'(err));
    apb_transfer(1'b1, `REG_PAD1_D0, 16'hffff, rd, err, waits);
    expect_word("decoded write slverr", 16'h0001, periph_pkg::word_t'(err));
    read_reg(`REG_PAD1_D0, rd);
    expect_word("decoded word kept", decode_fields(pad_img[0], 0), rd);
    report_test();

    start_test("ticks");
    read_reg(`REG_TICKS, w1);
    read_reg(`REG_TICKS, w2);
    expect_word("tick delta", 16'd2, w2 - w1);
    report_test();

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
